// File: rtl/async_fifo_pkg.sv
// ------------------------------------------------------------
// async fifo package
// word, address and pointer widths shared by the FIFO blocks
// ------------------------------------------------------------
`default_nettype none

package async_fifo_pkg;

	// sizes
	localparam int DATA_WIDTH = 8;
	localparam int PTR_WIDTH  = 4;
	localparam int FIFO_DEPTH = 1 << PTR_WIDTH;

	// one stored word
	typedef logic [DATA_WIDTH-1:0] data_t;

	// RAM address
	typedef logic [PTR_WIDTH-1:0] addr_t;

	// pointer and count with an extra msb that tells full from empty
	typedef logic [PTR_WIDTH:0] ptr_t;

endpackage

`default_nettype wire

// File: rtl/fifo_ram_if.sv
// ------------------------------------------------------------
// FIFO RAM bus
// write port on the input clock, read port on the output clock
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface fifo_ram_if;
	import async_fifo_pkg::*;

	// write port
	logic  wr_en;
	addr_t wr_addr;
	data_t wr_data;

	// read port is always enabled
	addr_t rd_addr;
	data_t rd_data;

	modport writer (
		output wr_en,
		output wr_addr,
		output wr_data
	);

	modport reader (
		output rd_addr,
		input  rd_data
	);

	modport ram (
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  rd_addr,
		output rd_data
	);

endinterface

`default_nettype wire

// File: rtl/fifo_dual_port_ram.sv
// ------------------------------------------------------------
// two-clock dual-port RAM
// writes on in_clk, registered read on out_clk
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifo_dual_port_ram (
	input  logic          in_clk,
	input  logic          out_clk,
	fifo_ram_if.ram       ram
);
	import async_fifo_pkg::*;

	// storage array
	data_t mem [FIFO_DEPTH];

	// ------------------------------------------------------------
	// write port
	// ------------------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (ram.wr_en) begin
			mem[ram.wr_addr] <= ram.wr_data;
		end
	end

	// ------------------------------------------------------------
	// read port
	// ------------------------------------------------------------
	// word at rd_addr shows one out_clk edge later
	always_ff @(posedge out_clk) begin
		ram.rd_data <= mem[ram.rd_addr];
	end

endmodule

`default_nettype wire

// File: rtl/gray_ptr_sync.sv
// ------------------------------------------------------------
// pointer clock crossing
// binary to gray, two-flop sync, gray back to binary
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync (
	input  logic                 reset,
	input  logic                 src_clk,
	input  logic                 dst_clk,
	input  async_fifo_pkg::ptr_t src_ptr,
	output async_fifo_pkg::ptr_t dst_ptr
);
	import async_fifo_pkg::*;

	ptr_t src_gray;
	ptr_t sync_ff1;
	ptr_t sync_ff2;

	function automatic ptr_t bin_to_gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	function automatic ptr_t gray_to_bin(input ptr_t gray);
		ptr_t bin;
		bin[PTR_WIDTH] = gray[PTR_WIDTH];
		for (int i = PTR_WIDTH - 1; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

	// source side where only one bit moves per increment
	always_ff @(posedge src_clk or posedge reset) begin
		if (reset) begin
			src_gray <= '0;
		end else begin
			src_gray <= bin_to_gray(src_ptr);
		end
	end

	// destination side
	always_ff @(posedge dst_clk or posedge reset) begin
		if (reset) begin
			sync_ff1 <= '0;
			sync_ff2 <= '0;
			dst_ptr  <= '0;
		end else begin
			sync_ff1 <= src_gray;
			sync_ff2 <= sync_ff1;
			dst_ptr  <= gray_to_bin(sync_ff2);
		end
	end

endmodule

`default_nettype wire

// File: rtl/fifo_write_ctrl.sv
// ------------------------------------------------------------
// FIFO write side
// write pointer, full flag, RAM write strobe, free space
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifo_write_ctrl (
	input  logic                  reset,
	input  logic                  in_clk,
	input  logic                  in_en,
	input  async_fifo_pkg::data_t in_data,
	output logic                  in_ready,
	output async_fifo_pkg::ptr_t  in_free_num,
	output async_fifo_pkg::ptr_t  wr_ptr,
	input  async_fifo_pkg::ptr_t  synced_rd_ptr,
	fifo_ram_if.writer            ram
);
	import async_fifo_pkg::*;

	logic full;
	logic wr_accept;

	// same address, opposite wrap bit
	assign full = (wr_ptr[PTR_WIDTH] != synced_rd_ptr[PTR_WIDTH]) &&
		(wr_ptr[PTR_WIDTH-1:0] == synced_rd_ptr[PTR_WIDTH-1:0]);

	assign in_ready  = !full;
	assign wr_accept = in_en && in_ready;

	// ------------------------------------------------------------
	// pointer
	// ------------------------------------------------------------
	always_ff @(posedge in_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (wr_accept) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// RAM write port
	assign ram.wr_en   = wr_accept;
	assign ram.wr_addr = wr_ptr[PTR_WIDTH-1:0];
	assign ram.wr_data = in_data;

	// pessimistic as the synced read pointer lags
	assign in_free_num = ptr_t'(FIFO_DEPTH) - (wr_ptr - synced_rd_ptr);

endmodule

`default_nettype wire

// File: rtl/fifo_read_ctrl.sv
// ------------------------------------------------------------
// FIFO read side
// read pointer, empty flag, fall-through output with hold reg
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifo_read_ctrl (
	input  logic                  reset,
	input  logic                  out_clk,
	output logic                  out_en,
	output async_fifo_pkg::data_t out_data,
	input  logic                  out_ready,
	output async_fifo_pkg::ptr_t  out_data_num,
	output async_fifo_pkg::ptr_t  rd_ptr,
	input  async_fifo_pkg::ptr_t  synced_wr_ptr,
	fifo_ram_if.reader            ram
);
	import async_fifo_pkg::*;

	logic  empty;
	logic  rd_advance;

	// RAM output stage
	logic  ram_valid;

	// hold register
	data_t hold_data;
	logic  hold_valid;

	assign empty = (synced_wr_ptr == rd_ptr);

	// fetch while output is free or being taken
	assign rd_advance = !empty && (out_ready || !out_en);

	// ------------------------------------------------------------
	// pointer and valid bits
	// ------------------------------------------------------------
	always_ff @(posedge out_clk or posedge reset) begin
		if (reset) begin
			rd_ptr     <= '0;
			ram_valid  <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (rd_advance) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			ram_valid <= !empty;
			// hold the visible word while the reader stalls
			if (out_ready) begin
				hold_valid <= 1'b0;
			end else if (!hold_valid) begin
				hold_valid <= ram_valid;
			end
		end
	end

	// ------------------------------------------------------------
	// hold data
	// ------------------------------------------------------------
	always_ff @(posedge out_clk) begin
		if (!out_ready && !hold_valid) begin
			hold_data <= ram.rd_data;
		end
	end

	assign ram.rd_addr = rd_ptr[PTR_WIDTH-1:0];

	// hold register is the older word and has priority
	assign out_en   = hold_valid || ram_valid;
	assign out_data = hold_valid ? hold_data : ram.rd_data;

	// words still behind the output stage
	assign out_data_num = synced_wr_ptr - rd_ptr;

endmodule

`default_nettype wire

// File: rtl/async_fifo_fwft.sv
// ------------------------------------------------------------
// first-word fall-through async FIFO
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module async_fifo_fwft (
	input  logic                  reset,

	input  logic                  in_clk,
	input  logic                  in_en,
	input  async_fifo_pkg::data_t in_data,
	output logic                  in_ready,
	output async_fifo_pkg::ptr_t  in_free_num,

	input  logic                  out_clk,
	output logic                  out_en,
	output async_fifo_pkg::data_t out_data,
	input  logic                  out_ready,
	output async_fifo_pkg::ptr_t  out_data_num
);
	import async_fifo_pkg::*;

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	ptr_t synced_wr_ptr;
	ptr_t synced_rd_ptr;

	fifo_ram_if ram_bus ();

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	fifo_dual_port_ram u_ram (
		.in_clk  (in_clk),
		.out_clk (out_clk),
		.ram     (ram_bus.ram)
	);

	// ------------------------------------------------------------
	// write and read sides
	// ------------------------------------------------------------
	fifo_write_ctrl u_write_ctrl (
		.reset         (reset),
		.in_clk        (in_clk),
		.in_en         (in_en),
		.in_data       (in_data),
		.in_ready      (in_ready),
		.in_free_num   (in_free_num),
		.wr_ptr        (wr_ptr),
		.synced_rd_ptr (synced_rd_ptr),
		.ram           (ram_bus.writer)
	);

	fifo_read_ctrl u_read_ctrl (
		.reset         (reset),
		.out_clk       (out_clk),
		.out_en        (out_en),
		.out_data      (out_data),
		.out_ready     (out_ready),
		.out_data_num  (out_data_num),
		.rd_ptr        (rd_ptr),
		.synced_wr_ptr (synced_wr_ptr),
		.ram           (ram_bus.reader)
	);

	// ------------------------------------------------------------
	// pointer crossings
	// ------------------------------------------------------------
	gray_ptr_sync u_wptr_sync (
		.reset   (reset),
		.src_clk (in_clk),
		.dst_clk (out_clk),
		.src_ptr (wr_ptr),
		.dst_ptr (synced_wr_ptr)
	);

	gray_ptr_sync u_rptr_sync (
		.reset   (reset),
		.src_clk (out_clk),
		.dst_clk (in_clk),
		.src_ptr (rd_ptr),
		.dst_ptr (synced_rd_ptr)
	);

endmodule

`default_nettype wire

// File: dv/tb_async_fifo_fwft.sv
// ------------------------------------------------------------
// testbench for the first-word fall-through async FIFO
// random traffic on two unrelated clocks against a queue model
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_async_fifo_fwft;
	import async_fifo_pkg::*;

	localparam int IN_HALF        = 50;
	localparam int OUT_HALF       = 65;
	localparam int RESET_CYCLES   = 4;
	localparam int PRIME_CYCLES   = 30;
	localparam int FILL_CYCLES    = 60;
	localparam int RANDOM_CYCLES  = 2000;
	localparam int IDLE_CYCLES    = 30;
	localparam int DRAIN_CYCLES   = 60;
	localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + PRIME_CYCLES + FILL_CYCLES +
		RANDOM_CYCLES + IDLE_CYCLES + DRAIN_CYCLES);

	logic  reset;
	logic  in_clk = 1'b0;
	logic  out_clk = 1'b0;
	logic  in_en;
	data_t in_data;
	logic  in_ready;
	ptr_t  in_free_num;
	logic  out_en;
	data_t out_data;
	logic  out_ready;
	ptr_t  out_data_num;

	logic [31:0] rng_state = 32'h81b5;
	data_t model_q[$];
	int    in_pct = 0;
	int    out_pct = 0;
	bit    fill_check = 1'b0;
	int    fill_base = 0;
	int    write_count = 0;
	int    cycle_count = 0;

	// rising edges of the two clocks never line up
	always #IN_HALF in_clk = ~in_clk;
	always #OUT_HALF out_clk = ~out_clk;

	async_fifo_fwft u_async_fifo_fwft (
		.reset        (reset),
		.in_clk       (in_clk),
		.in_en        (in_en),
		.in_data      (in_data),
		.in_ready     (in_ready),
		.in_free_num  (in_free_num),
		.out_clk      (out_clk),
		.out_en       (out_en),
		.out_data     (out_data),
		.out_ready    (out_ready),
		.out_data_num (out_data_num)
	);

	// ------------------------------------------------------------
	// random numbers and checks
	// ------------------------------------------------------------
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic chance(input int pct);
		return int'(next_random() % 32'd100) < pct;
	endfunction

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			stop_with_error($sformatf("Fail at %0t: %s is 0x%02h, expected 0x%02h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_count(input ptr_t got, input ptr_t exp, input string what);
		if (got !== exp) begin
			stop_with_error($sformatf("Fail at %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_with_error($sformatf("Fail at %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	always @(posedge in_clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			stop_with_error($sformatf("timeout, no result after %0d in_clk cycles",
				TIMEOUT_CYCLES));
		end
	end

	// ------------------------------------------------------------
	// write side driver and model push
	// ------------------------------------------------------------
	initial begin
		logic ready_seen;
		ready_seen = 1'b0;
		in_en = 1'b0;
		in_data = '0;
		forever begin
			@(posedge in_clk);
			#1;
			// handshake of the edge just passed
			if (in_en && ready_seen) begin
				model_q.push_back(in_data);
				write_count++;
				if (fill_check) begin
					check_count(in_free_num, ptr_t'(FIFO_DEPTH - (write_count - fill_base)),
						"in_free_num after write");
				end
			end
			ready_seen = in_ready;
			in_en = chance(in_pct);
			in_data = data_t'(next_random());
		end
	end

	// ------------------------------------------------------------
	// read side driver, model pop and stall check
	// ------------------------------------------------------------
	initial begin
		logic  en_seen;
		data_t data_seen;
		data_t expected;
		en_seen = 1'b0;
		data_seen = '0;
		out_ready = 1'b0;
		forever begin
			@(posedge out_clk);
			#1;
			if (en_seen && out_ready) begin
				if (model_q.size() == 0) begin
					stop_with_error("read side handed out a word that was never written");
				end else begin
					expected = model_q.pop_front();
					check_data(data_seen, expected, "out_data order");
				end
			end else if (en_seen) begin
				// stalled word must stay put
				check_flag(out_en, 1'b1, "out_en while stalled");
				check_data(out_data, data_seen, "out_data while stalled");
			end
			en_seen = out_en;
			data_seen = out_data;
			out_ready = chance(out_pct);
		end
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		int held;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge in_clk);
		#1;
		reset = 1'b0;

		@(negedge in_clk);
		check_flag(out_en, 1'b0, "out_en after reset");
		check_flag(in_ready, 1'b1, "in_ready after reset");
		check_count(in_free_num, ptr_t'(FIFO_DEPTH), "in_free_num after reset");
		check_count(out_data_num, '0, "out_data_num after reset");

		// one word falls through and leaves the RAM for the output stage
		@(posedge in_clk);
		in_pct = 100;
		@(posedge in_clk);
		in_pct = 0;
		while (!out_en) @(negedge in_clk);
		repeat (10) @(negedge in_clk);
		check_count(in_free_num, ptr_t'(FIFO_DEPTH), "in_free_num with first word fetched");

		$display("fill with out_ready low");
		@(posedge in_clk);
		fill_base = write_count;
		fill_check = 1'b1;
		in_pct = 70;
		while (write_count - fill_base < FIFO_DEPTH) @(negedge in_clk);
		check_flag(in_ready, 1'b0, "in_ready after 16 writes");
		@(posedge in_clk);
		in_pct = 100;
		repeat (8) @(negedge in_clk);
		check_count(ptr_t'(write_count - fill_base), ptr_t'(FIFO_DEPTH), "writes while full");
		check_count(in_free_num, '0, "in_free_num while full");

		$display("random traffic");
		@(posedge in_clk);
		fill_check = 1'b0;
		in_pct = 45;
		out_pct = 65;
		repeat (RANDOM_CYCLES) @(posedge in_clk);

		$display("idle with out_ready low");
		out_pct = 0;
		in_pct = 100;
		repeat (4) @(posedge in_clk);
		in_pct = 0;
		repeat (10) @(posedge out_clk);
		@(negedge out_clk);
		held = model_q.size();
		// during a stall only the held word is past the read pointer
		check_count(out_data_num, ptr_t'((held > 0) ? held - 1 : 0), "out_data_num when idle");
		check_flag(out_en, held != 0, "out_en when idle");

		$display("drain");
		@(posedge in_clk);
		out_pct = 100;
		repeat (2) @(negedge out_clk);
		while (out_en) @(negedge out_clk);
		check_count(ptr_t'(model_q.size()), '0, "model words left after drain");
		repeat (10) @(negedge in_clk);
		check_count(in_free_num, ptr_t'(FIFO_DEPTH), "in_free_num after drain");
		check_count(out_data_num, '0, "out_data_num after drain");

		$display("%0d words written", write_count);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
rtl/async_fifo_pkg.sv
rtl/fifo_ram_if.sv
rtl/fifo_dual_port_ram.sv
rtl/gray_ptr_sync.sv
rtl/fifo_write_ctrl.sv
rtl/fifo_read_ctrl.sv
rtl/async_fifo_fwft.sv
dv/tb_async_fifo_fwft.sv

// File: Makefile
# Verilator build and run of the async FWFT FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_async_fifo_fwft
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
